// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pipeTb
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: addStage.sv
/*
 * EX2 and write-back. Forwarding from write-back, the add-4 adder,
 * the EX2/WB register and the late skip mux that forms the write-back value
 */
`timescale 1ns/1ps

module addStage
	import pipePkg::*;
(
	input  logic   CLK,
	input  logic   RSTB,
	input  opT     ex2Op,
	input  regIdxT ex2Ra,
	input  dataT   ex2Xd,
	input  logic   ex2Xmex1,
	output dataT   ex2AdderIn,
	output logic   active,
	output logic   wbWrite,
	output regIdxT wbRa,
	output dataT   wbData
);

	logic forw2;
	logic skip2;
	dataT adderOut;
	dataT wbAdderIn;
	dataT wbAdderOut;
	logic wbSkip2;

	// ADD4 and MOV take their operand here, so they may still need the write-back value
	// SUB3 and ADD1 already got theirs in EX1
	assign forw2 = ex2Xmex1 & (ex2Op[OP_ADD4] | ex2Op[OP_MOV]) & wbWrite;

	assign ex2AdderIn = forw2 ? wbData : ex2Xd;
	assign adderOut   = ex2AdderIn + dataT'(ADD_AMOUNT);

	// Only ADD4 and ADD1 keep the adder result
	assign skip2 = ~(ex2Op[OP_ADD4] | ex2Op[OP_ADD1]);

	// Late skip mux, placed after the EX2/WB register
	assign wbData = wbSkip2 ? wbAdderIn : wbAdderOut;

	// EX2 or write-back holds a live instruction
	assign active = (|ex2Op) | wbWrite;

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
			wbWrite <= 1'b0;
		else
			wbWrite <= |ex2Op;
	end

	// Both adder sides travel into write-back with their select
	always_ff @(posedge CLK)
	begin
		wbRa       <= ex2Ra;
		wbAdderIn  <= ex2AdderIn;
		wbAdderOut <= adderOut;
		wbSkip2    <= skip2;
	end

endmodule

// File: apbHostPort.sv
/*
 * APB3 slave of the pipeline. Decodes the address map, adds one wait state,
 * holds the run bit and turns accepted writes into memory and register strobes
 */
`timescale 1ns/1ps

module apbHostPort
	import pipePkg::*;
(
	input  logic                          CLK,
	input  logic                          RSTB,
	input  logic                          PSEL,
	input  logic                          PENABLE,
	input  logic                          PWRITE,
	input  apbAddrT                       PADDR,
	input  logic [31:0]                   PWDATA,
	input  logic                          runDone,
	input  logic                          busy,
	input  pcT                            pc,
	input  dataT                          rfRdata,
	output logic [31:0]                   PRDATA,
	output logic                          PREADY,
	output logic                          PSLVERR,
	output logic                          run,
	output logic                          imemWe,
	output logic [$clog2(IMEM_DEPTH)-1:0] imemAddr,
	output instrT                         imemWdata,
	output logic                          rfWe,
	output regIdxT                        rfAddr,
	output dataT                          rfWdata
);

	logic        inImem;
	logic        inReg;
	logic        isCtrl;
	logic        isPc;
	logic        accessErr;
	logic        firstAccess;
	logic        wrOk;
	logic [31:0] rdMux;

	// Region decode by the offset from each base
	// The two low address bits are ignored
	assign inImem = apbAddrT'(PADDR - IMEM_BASE) < apbAddrT'(IMEM_DEPTH * 4);
	assign inReg  = apbAddrT'(PADDR - REG_BASE) < apbAddrT'((2 ** REG_IDX_W) * 4);
	assign isCtrl = (PADDR[APB_ADDR_W-1:2] == CTRL_ADDR[APB_ADDR_W-1:2]);
	assign isPc   = (PADDR[APB_ADDR_W-1:2] == PC_ADDR[APB_ADDR_W-1:2]);

	// Storage is reachable only while the pipeline is idle
	// The pc register is read-only
	assign accessErr = ~(inImem | inReg | isCtrl | isPc)
		| ((inImem | inReg) & (run | busy))
		| (isPc & PWRITE);

	// The first cycle of the access phase is always the wait state
	assign firstAccess = PSEL & PENABLE & ~PREADY;

	// A write takes effect in the completing cycle, unless it was rejected
	assign wrOk = PSEL & PENABLE & PREADY & PWRITE & ~PSLVERR;

	// Word addresses and write data go straight through to the storage blocks
	assign imemWe    = wrOk & inImem;
	assign imemAddr  = PADDR[2 +: $clog2(IMEM_DEPTH)];
	assign imemWdata = PWDATA;
	assign rfWe      = wrOk & inReg;
	assign rfAddr    = PADDR[2 +: REG_IDX_W];
	assign rfWdata   = PWDATA[DATA_W-1:0];

	// Read data source
	// The instruction memory is write-only and reads as zero
	always_comb
	begin
		if (inReg)
			rdMux = 32'(rfRdata);
		else if (isCtrl)
			rdMux = {30'b0, busy, run};
		else if (isPc)
			rdMux = 32'(pc);
		else
			rdMux = '0;
	end

	// PREADY rises in the second access cycle and drops right after it
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			PREADY  <= 1'b0;
			PSLVERR <= 1'b0;
		end
		else
		begin
			PREADY  <= firstAccess;
			PSLVERR <= firstAccess & accessErr;
		end
	end

	// Read data is captured together with PREADY
	always_ff @(posedge CLK)
	begin
		if (firstAccess)
			PRDATA <= rdMux;
	end

	// Host sets or clears run, and the end of the program clears it
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
			run <= 1'b0;
		else if (wrOk & isCtrl)
			run <= PWDATA[0];
		else if (runDone)
			run <= 1'b0;
	end

endmodule

// File: decodeRegFile.sv
/*
 * Decode stage. Register file with write-back bypass, source comparators,
 * load-use stall detection and the ID/EX1 register
 */
`timescale 1ns/1ps

module decodeRegFile
	import pipePkg::*;
(
	input  logic   CLK,
	input  logic   RSTB,
	input  instrT  idInstr,
	input  regIdxT ex2Ra,
	input  logic   wbWrite,
	input  regIdxT wbRa,
	input  dataT   wbData,
	input  logic   rfWe,
	input  regIdxT rfAddr,
	input  dataT   rfWdata,
	output logic   stall,
	output dataT   rfRdata,
	output logic   active,
	output opT     ex1Op,
	output regIdxT ex1Ra,
	output dataT   ex1Xd,
	output logic   ex1Xmex1,
	output logic   ex1Xmex2
);

	dataT   regs [2 ** REG_IDX_W];
	opT     idOp;
	regIdxT idRa;
	regIdxT idXa;
	dataT   idXd;
	logic   idXmex1;
	logic   idXmex2;

	// Field extraction from the one-hot instruction format
	assign idOp = idInstr[OP_MOV:OP_ADD1];
	assign idRa = idInstr[RA_LSB +: REG_IDX_W];
	assign idXa = idInstr[XA_LSB +: REG_IDX_W];

	// Source read, bypassing the value being written back in this same cycle
	assign idXd = (wbWrite && (wbRa == idXa)) ? wbData : regs[idXa];

	// Host read port, only meaningful while the pipeline is idle
	assign rfRdata = regs[rfAddr];

	// Comparators against the destinations now in EX1 and EX2
	// They travel with the instruction and select forwarding one and two stages later
	assign idXmex1 = (idXa == ex1Ra);
	assign idXmex2 = (idXa == ex2Ra);

	// A SUB3 or ADD1 needs its operand at the start of EX1
	// An ADD4 or ADD1 just ahead has its result only at the end of EX2, so wait one cycle
	assign stall = idXmex1
		& (idOp[OP_SUB3] | idOp[OP_ADD1])
		& (ex1Op[OP_ADD4] | ex1Op[OP_ADD1]);

	// Decode or EX1 holds a live instruction
	assign active = (|idOp) | (|ex1Op);

	// Write-back has the port during a run, the host only while idle
	always_ff @(posedge CLK)
	begin
		if (wbWrite)
			regs[wbRa] <= wbData;
		else if (rfWe)
			regs[rfAddr] <= rfWdata;
	end

	// On a stall a bubble goes into EX1 while the instruction waits in decode
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
			ex1Op <= '0;
		else
			ex1Op <= stall ? opT'(0) : idOp;
	end

	// Payload of ID/EX1, qualified downstream by the opcode
	always_ff @(posedge CLK)
	begin
		ex1Ra    <= idRa;
		ex1Xd    <= idXd;
		ex1Xmex1 <= idXmex1;
		ex1Xmex2 <= idXmex2;
	end

endmodule

// File: filelist.f
pipePkg.sv
apbHostPort.sv
instrFetch.sv
decodeRegFile.sv
subtractStage.sv
addStage.sv
pipeTop.sv
pipeTop_checker.sv
pipeTb.sv

// File: instrFetch.sv
/*
 * Fetch stage. Instruction memory, program counter that stops after the last
 * word, and the IF/ID register that holds during a decode stall
 */
`timescale 1ns/1ps

module instrFetch
	import pipePkg::*;
(
	input  logic                          CLK,
	input  logic                          RSTB,
	input  logic                          run,
	input  logic                          stall,
	input  logic                          imemWe,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imemAddr,
	input  instrT                         imemWdata,
	output instrT                         idInstr,
	output pcT                            pc,
	output logic                          runDone
);

	instrT                         imem [IMEM_DEPTH];
	logic                          runQ;
	logic                          start;
	logic                          fetch;
	logic [$clog2(IMEM_DEPTH)-1:0] rdIdx;

	// A new run begins on the rising edge of run and spends one cycle clearing pc
	assign start = run & ~runQ;
	// Fetching stops once pc has passed the last word
	assign fetch = run & ~start & (pc < pcT'(IMEM_DEPTH));
	assign rdIdx = pc[$clog2(IMEM_DEPTH)-1:0];

	// Host loads the program through the APB port while idle
	always_ff @(posedge CLK)
	begin
		if (imemWe)
			imem[imemAddr] <= imemWdata;
	end

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			runQ    <= 1'b0;
			runDone <= 1'b0;
			pc      <= '0;
			idInstr <= '0;
		end
		else
		begin
			runQ    <= run;
			// Pulses once, in the cycle after word 63 enters IF/ID
			runDone <= fetch & ~stall & (pc == pcT'(IMEM_DEPTH - 1));
			if (start)
				pc <= '0;
			else if (fetch & ~stall)
				pc <= pc + pcT'(1);
			// Stalled instruction stays in decode, an idle fetch feeds NOPs
			if (!stall)
				idInstr <= fetch ? imem[rdIdx] : '0;
		end
	end

endmodule

// File: pipePkg.sv
/*
 * Shared definitions for the five-stage pipeline and its APB host port.
 * Holds the widths, opcode bit positions, adder constants, APB address map and types
 */
package pipePkg;

	// Data path and storage sizes
	localparam int DATA_W     = 16;
	localparam int REG_IDX_W  = 4;
	localparam int INSTR_W    = 32;
	localparam int IMEM_DEPTH = 64;
	// Wide enough to hold IMEM_DEPTH itself, which marks the end of a run
	localparam int PC_W       = 8;

	// Constants of the subtract and add stages
	localparam int SUB_AMOUNT = 3;
	localparam int ADD_AMOUNT = 4;

	// One-hot opcode bits in the instruction word
	localparam int OP_MOV  = 31;
	localparam int OP_SUB3 = 30;
	localparam int OP_ADD4 = 29;
	localparam int OP_ADD1 = 28;
	// Destination and source register fields
	localparam int RA_LSB  = 4;
	localparam int XA_LSB  = 0;

	localparam int APB_ADDR_W = 12;

	typedef logic [DATA_W-1:0]     dataT;
	typedef logic [REG_IDX_W-1:0]  regIdxT;
	typedef logic [INSTR_W-1:0]    instrT;
	typedef logic [PC_W-1:0]       pcT;
	// Indexed by the opcode bit positions, so op[OP_ADD4] reads the ADD4 bit
	// An all-zero opcode is a NOP or a bubble
	typedef logic [OP_MOV:OP_ADD1] opT;
	typedef logic [APB_ADDR_W-1:0] apbAddrT;

	// APB byte address map, all registers are word aligned
	localparam apbAddrT IMEM_BASE = 12'h000;
	localparam apbAddrT REG_BASE  = 12'h100;
	// Bit 0 is run, bit 1 is the read-only busy flag
	localparam apbAddrT CTRL_ADDR = 12'h200;
	localparam apbAddrT PC_ADDR   = 12'h204;

endpackage

// File: pipeTb.sv
/*
 * Testbench for pipeTop. Loads registers and programs over APB from the
 * stimulus file, runs them and compares the final registers and pc
 */
`timescale 1ns/1ps

module pipeTb
	import pipePkg::*;
();

	localparam int APB_LIMIT  = 20;
	localparam int POLL_LIMIT = 400;
	localparam int NUM_REGS   = 2 ** REG_IDX_W;

	logic        CLK;
	logic        RSTB;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	apbAddrT     PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;

	// Per-test state filled from the stimulus file
	dataT        initVal [NUM_REGS];
	dataT        expVal  [NUM_REGS];
	instrT       prog    [IMEM_DEPTH];
	pcT          expPc;
	logic [31:0] lfsrState;

	pipeTop u_pipeTop (
		.CLK, .RSTB, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.PRDATA, .PREADY, .PSLVERR
	);

	always #2 CLK = ~CLK;

	// Prints the reason, then ends the run as a failure
	task automatic failNow(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input dataT got, input dataT exp);
		if (got !== exp)
			failNow($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkPc(input string name, input pcT got, input pcT exp);
		if (got !== exp)
			failNow($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkErr(input string name, input logic got, input logic exp);
		if (got !== exp)
			failNow($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per data bit
	task automatic randomData(output dataT v);
		v = '0;
		for (int b = 0; b < DATA_W; b++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[DATA_W-2:0], lfsrState[0]};
		end
	endtask

	// One APB transfer with outputs sampled on the falling edge where they are stable
	task automatic apbXfer(input logic wr, input apbAddrT addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int n;
		@(posedge CLK);
		PSEL    <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE  <= wr;
		PADDR   <= addr;
		PWDATA  <= wdata;
		@(posedge CLK);
		PENABLE <= 1'b1;
		n = 0;
		@(negedge CLK);
		while (!PREADY && n < APB_LIMIT)
		begin
			@(negedge CLK);
			n++;
		end
		if (!PREADY)
			failNow($sformatf("APB transfer to 0x%h never completed", addr));
		rdata = PRDATA;
		err   = PSLVERR;
		@(posedge CLK);
		PSEL    <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic apbWrite(input apbAddrT addr, input logic [31:0] wdata, input logic expErr);
		logic [31:0] rd;
		logic        err;
		apbXfer(1'b1, addr, wdata, rd, err);
		checkErr($sformatf("PSLVERR write 0x%h", addr), err, expErr);
	endtask

	task automatic apbRead(input apbAddrT addr, output logic [31:0] rdata);
		logic err;
		apbXfer(1'b0, addr, 32'h0, rdata, err);
		checkErr($sformatf("PSLVERR read 0x%h", addr), err, 1'b0);
	endtask

	function automatic apbAddrT regAddr(input int idx);
		return REG_BASE + apbAddrT'(idx * 4);
	endfunction

	// Loads one test, runs it and compares the final state
	task automatic runTest(input int testNum);
		logic [31:0] rd;
		logic        err;
		int          n;
		// Registers written while idle must read back unchanged
		for (int i = 0; i < NUM_REGS; i++)
			apbWrite(regAddr(i), 32'(initVal[i]), 1'b0);
		for (int i = 0; i < NUM_REGS; i++)
		begin
			apbRead(regAddr(i), rd);
			checkData($sformatf("test %0d load r%0d", testNum, i), rd[DATA_W-1:0], initVal[i]);
		end
		// Whole memory is rewritten so old programs leave no words behind
		for (int a = 0; a < IMEM_DEPTH; a++)
			apbWrite(IMEM_BASE + apbAddrT'(a * 4), prog[a], 1'b0);
		apbWrite(CTRL_ADDR, 32'h1, 1'b0);
		// Storage is locked while running so these must be rejected and change nothing
		// A leaked write to the last word would still be fetched and alter the results
		apbXfer(1'b1, IMEM_BASE + apbAddrT'((IMEM_DEPTH - 1) * 4), 32'hFFFF_FFFF, rd, err);
		checkErr("PSLVERR imem write in run", err, 1'b1);
		apbXfer(1'b1, regAddr(NUM_REGS - 1), 32'h0000_DEAD, rd, err);
		checkErr("PSLVERR reg write in run", err, 1'b1);
		apbXfer(1'b0, regAddr(0), 32'h0, rd, err);
		checkErr("PSLVERR reg read in run", err, 1'b1);
		// Done when both run and busy read zero
		n = 0;
		apbRead(CTRL_ADDR, rd);
		while (rd[1:0] != 2'b00 && n < POLL_LIMIT)
		begin
			apbRead(CTRL_ADDR, rd);
			n++;
		end
		if (rd[1:0] != 2'b00)
			failNow($sformatf("test %0d never went idle", testNum));
		apbRead(PC_ADDR, rd);
		checkPc($sformatf("test %0d pc", testNum), rd[PC_W-1:0], expPc);
		for (int i = 0; i < NUM_REGS; i++)
		begin
			apbRead(regAddr(i), rd);
			checkData($sformatf("test %0d r%0d", testNum, i), rd[DATA_W-1:0], expVal[i]);
			// Register reads are zero-extended to the full bus
			checkData($sformatf("test %0d r%0d upper", testNum, i), rd[31:DATA_W], '0);
		end
	endtask

	initial
	begin
		int             fd;
		int             r;
		int             idx;
		int             testNum;
		logic [31:0]    val;
		logic [7:0]     tag;
		logic [1023:0]  lineBuf;
		logic [31:0]    rd;
		logic           err;
		logic           done;
		CLK       = 1'b0;
		RSTB      = 1'b0;
		PSEL      = 1'b0;
		PENABLE   = 1'b0;
		PWRITE    = 1'b0;
		PADDR     = '0;
		PWDATA    = '0;
		lfsrState = 32'h47d943d1;
		testNum   = 0;
		repeat (10) @(posedge CLK);
		RSTB <= 1'b1;
		// Address map errors that need no program
		apbWrite(PC_ADDR, 32'h5, 1'b1);
		apbXfer(1'b0, 12'h300, 32'h0, rd, err);
		checkErr("PSLVERR unmapped read", err, 1'b1);
		fd = $fopen("pipe_stimulus.txt", "r");
		if (fd == 0)
			failNow("could not open pipe_stimulus.txt");
		done = 1'b0;
		while (!done)
		begin
			r = $fscanf(fd, " %s", tag);
			if (r != 1)
				failNow("stimulus file ended without an end tag");
			if (tag == "#")
				r = $fgets(lineBuf, fd);
			else if (tag == "T")
			begin
				r = $fscanf(fd, " %d", testNum);
				// Unlisted registers get random values and must keep them
				for (int i = 0; i < NUM_REGS; i++)
				begin
					randomData(initVal[i]);
					expVal[i] = initVal[i];
				end
				for (int a = 0; a < IMEM_DEPTH; a++)
					prog[a] = '0;
			end
			else if (tag == "R")
			begin
				r = $fscanf(fd, " %d %h", idx, val);
				initVal[idx] = val[DATA_W-1:0];
				expVal[idx]  = val[DATA_W-1:0];
			end
			else if (tag == "M")
			begin
				r = $fscanf(fd, " %d %h", idx, val);
				prog[idx] = val;
			end
			else if (tag == "X")
			begin
				r = $fscanf(fd, " %d %h", idx, val);
				expVal[idx] = val[DATA_W-1:0];
			end
			else if (tag == "P")
			begin
				r = $fscanf(fd, " %d", idx);
				expPc = pcT'(idx);
				runTest(testNum);
			end
			else if (tag == "E")
				done = 1'b1;
			else
				failNow("unknown tag in stimulus file");
		end
		$fclose(fd);
		$display("Test passed");
		$finish;
	end

endmodule

// File: pipeTop.sv
/*
 * Top level of the pipeline. Connects the APB host port to fetch,
 * decode, the two execute stages and write-back
 */
`timescale 1ns/1ps

module pipeTop
	import pipePkg::*;
(
	input  logic        CLK,
	input  logic        RSTB,
	input  logic        PSEL,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  apbAddrT     PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR
);

	// Host access paths
	logic                          run;
	logic                          runDone;
	logic                          busy;
	pcT                            pc;
	logic                          imemWe;
	logic [$clog2(IMEM_DEPTH)-1:0] imemAddr;
	instrT                         imemWdata;
	logic                          rfWe;
	regIdxT                        rfAddr;
	dataT                          rfWdata;
	dataT                          rfRdata;

	// Pipeline nets, named by the stage that consumes them
	logic   stall;
	logic   decActive;
	logic   addActive;
	instrT  idInstr;
	opT     ex1Op;
	regIdxT ex1Ra;
	dataT   ex1Xd;
	logic   ex1Xmex1;
	logic   ex1Xmex2;
	opT     ex2Op;
	regIdxT ex2Ra;
	dataT   ex2Xd;
	logic   ex2Xmex1;
	dataT   ex2AdderIn;
	logic   wbWrite;
	regIdxT wbRa;
	dataT   wbData;

	// Busy while any stage from decode to write-back holds an instruction
	assign busy = decActive | addActive;

	apbHostPort u_apbHostPort (
		.CLK, .RSTB, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.runDone, .busy, .pc, .rfRdata,
		.PRDATA, .PREADY, .PSLVERR, .run,
		.imemWe, .imemAddr, .imemWdata, .rfWe, .rfAddr, .rfWdata
	);

	instrFetch u_instrFetch (
		.CLK, .RSTB, .run, .stall, .imemWe, .imemAddr, .imemWdata,
		.idInstr, .pc, .runDone
	);

	decodeRegFile u_decodeRegFile (
		.CLK, .RSTB, .idInstr, .ex2Ra, .wbWrite, .wbRa, .wbData,
		.rfWe, .rfAddr, .rfWdata,
		.stall, .rfRdata, .active(decActive),
		.ex1Op, .ex1Ra, .ex1Xd, .ex1Xmex1, .ex1Xmex2
	);

	subtractStage u_subtractStage (
		.CLK, .RSTB, .ex1Op, .ex1Ra, .ex1Xd, .ex1Xmex1, .ex1Xmex2,
		.wbWrite, .wbData, .ex2AdderIn,
		.ex2Op, .ex2Ra, .ex2Xd, .ex2Xmex1
	);

	addStage u_addStage (
		.CLK, .RSTB, .ex2Op, .ex2Ra, .ex2Xd, .ex2Xmex1,
		.ex2AdderIn, .active(addActive), .wbWrite, .wbRa, .wbData
	);

endmodule

// File: pipeTop_checker.sv
/*
 * Protocol and pipeline control checks for pipeTop.
 * Bound into the top level, so it sees the APB pins and the internal stall and pc
 */
`timescale 1ns/1ps

module pipeTop_checker
	import pipePkg::*;
(
	input logic CLK,
	input logic RSTB,
	input logic PSEL,
	input logic PENABLE,
	input logic PREADY,
	input logic PSLVERR,
	input logic stall,
	input pcT   pc
);

	// The slave only completes a transfer inside an access phase
	assert property (@(posedge CLK) disable iff (!RSTB) PREADY |-> (PSEL && PENABLE))
		else $error("PREADY raised outside an APB access phase");

	// An error response is only valid on the completing cycle
	assert property (@(posedge CLK) disable iff (!RSTB) PSLVERR |-> PREADY)
		else $error("PSLVERR raised without PREADY");

	// A stall lasts one cycle and holds the program counter while it waits
	assert property (@(posedge CLK) disable iff (!RSTB) stall |=> (!stall && $stable(pc)))
		else $error("stall lasted more than one cycle or pc moved during it");

	// The counter parks at the end marker and never runs past it
	assert property (@(posedge CLK) disable iff (!RSTB) pc <= pcT'(IMEM_DEPTH))
		else $error("pc went past the end of instruction memory");

endmodule

bind pipeTop pipeTop_checker u_pipeTopChecker (
	.CLK, .RSTB, .PSEL, .PENABLE, .PREADY, .PSLVERR, .stall, .pc
);

// File: pipe_stimulus.txt
# Tags: T test number, R reg(dec) initial(hex), M word(dec) instruction(hex)
# X reg(dec) expected final(hex), P expected pc(dec) runs the test, E ends the file
T 1
R 1 0010 R 2 0000 R 3 FFFE R 4 1234
M 0 80000051 M 1 40000062 M 2 20000073 M 3 10000084
X 5 0010 X 6 FFFD X 7 0002 X 8 1235
P 64
T 2
R 1 0100 R 10 0001
M 0 80000021 M 1 40000032 M 2 20000043 M 3 80000054 M 4 40000065
M 6 40000076 M 9 80000087 M 10 10000098 M 11 400000BA M 12 200000CB
X 2 0100 X 3 00FD X 4 0101 X 5 0101 X 6 00FE
X 7 00FB X 8 00FB X 9 00FC X 11 FFFE X 12 0002
P 64
T 3
R 1 FFFF
M 0 20000021 M 1 40000032 M 2 10000043 M 3 10000054 M 4 20000065
M 5 10000076 M 6 80000087 M 7 20000088 M 63 20000098
X 2 0003 X 3 0000 X 4 0001 X 5 0002 X 6 0006
X 7 0007 X 8 000B X 9 000F
P 64
E

// File: subtractStage.sv
/*
 * EX1 stage. Operand forwarding with EX2 priority over write-back,
 * the subtract-3 adder, its skip mux and the EX1/EX2 register
 */
`timescale 1ns/1ps

module subtractStage
	import pipePkg::*;
(
	input  logic   CLK,
	input  logic   RSTB,
	input  opT     ex1Op,
	input  regIdxT ex1Ra,
	input  dataT   ex1Xd,
	input  logic   ex1Xmex1,
	input  logic   ex1Xmex2,
	input  logic   wbWrite,
	input  dataT   wbData,
	input  dataT   ex2AdderIn,
	output opT     ex2Op,
	output regIdxT ex2Ra,
	output dataT   ex2Xd,
	output logic   ex2Xmex1
);

	logic prio;
	logic forw1;
	logic skip1;
	dataT prioXd;
	dataT adderIn;
	dataT adderOut;

	// A SUB3 or MOV in EX2 already holds its final value and is the newer producer
	assign prio  = ex1Xmex1 & (ex2Op[OP_SUB3] | ex2Op[OP_MOV]);
	assign forw1 = prio | (ex1Xmex2 & wbWrite);

	// The add stage input is taken, not its stored operand, so a MOV passes on forwarded data
	assign prioXd  = prio ? ex2AdderIn : wbData;
	assign adderIn = forw1 ? prioXd : ex1Xd;

	assign adderOut = adderIn - dataT'(SUB_AMOUNT);

	// Only SUB3 and ADD1 use the subtractor
	assign skip1 = ~(ex1Op[OP_SUB3] | ex1Op[OP_ADD1]);

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
			ex2Op <= '0;
		else
			ex2Op <= ex1Op;
	end

	// EX1/EX2 payload with the skip mux folded into the load
	always_ff @(posedge CLK)
	begin
		ex2Ra    <= ex1Ra;
		ex2Xd    <= skip1 ? adderIn : adderOut;
		ex2Xmex1 <= ex1Xmex1;
	end

endmodule
